// ==== common/eth_rx_pkg.sv ====
package eth_rx_pkg;

   // widths
   localparam int mac_addr_w      = 48;
   localparam int data_w          = 8;
   localparam int len_w           = 16;
   localparam int crc_w           = 32;
   localparam int buf_addr_w      = 11;
   localparam int buf_word_addr_w = 9;
   localparam int axi_addr_w      = 12;
   localparam int axi_data_w      = 32;

   localparam int max_payload = 1500;

   // frame constants
   localparam logic [data_w-1:0]     sfd_byte      = 8'hD5;
   localparam logic [data_w-1:0]     preamble_byte = 8'h55;
   localparam logic [crc_w-1:0]      crc_poly      = 32'hEDB88320;
   localparam logic [crc_w-1:0]      crc_residue   = 32'hDEBB20E3;
   localparam logic [mac_addr_w-1:0] broadcast_mac = '1;

   // host register map
   localparam logic [axi_addr_w-1:0] reg_status      = 12'h000;
   localparam logic [axi_addr_w-1:0] reg_control     = 12'h004;
   localparam logic [axi_addr_w-1:0] reg_mac_lo      = 12'h008;
   localparam logic [axi_addr_w-1:0] reg_mac_hi      = 12'h00C;
   localparam logic [axi_addr_w-1:0] reg_src_lo      = 12'h010;
   localparam logic [axi_addr_w-1:0] reg_src_hi      = 12'h014;
   localparam logic [axi_addr_w-1:0] reg_length      = 12'h018;
   localparam logic [axi_addr_w-1:0] reg_counters    = 12'h01C;
   localparam logic [axi_addr_w-1:0] buf_window_base = 12'h400;

   typedef enum logic [1:0] {
      rx_idle,
      rx_low_nibble,
      rx_high_nibble
   } rx_state_t;

   typedef enum logic [2:0] {
      ps_dest,
      ps_src,
      ps_len,
      ps_payload,
      ps_fcs,
      ps_discard,
      ps_wait_end
   } parse_state_t;

   typedef struct packed {
      logic              valid;
      logic              sof;
      logic              eof;
      logic [data_w-1:0] data;
   } rx_byte_t;

   typedef struct packed {
      logic                  en;
      logic [buf_addr_w-1:0] addr;
      logic [data_w-1:0]     data;
   } buf_wr_t;

   typedef struct packed {
      logic [mac_addr_w-1:0] src_mac;
      logic [len_w-1:0]      length;
   } frame_info_t;

endpackage

// ==== eth_rx/eth_crc32.sv ====
`timescale 1ns/100ps

module eth_crc32 (
   input  logic                 RX_CLK,
   input  logic                 rst,
   input  logic                 start,
   input  eth_rx_pkg::rx_byte_t in_byte,
   output logic                 crc_ok
);
   import eth_rx_pkg::*;

   logic [crc_w-1:0] crc_q;

   // reflected crc-32, one byte lsb first
   function automatic logic [crc_w-1:0] crc_next(
      input logic [crc_w-1:0]  crc,
      input logic [data_w-1:0] d
   );
      logic [crc_w-1:0] c;
      c = crc;
      for (int i = 0; i < data_w; i++) begin
         if (c[0] ^ d[i]) begin
            c = (c >> 1) ^ crc_poly;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         crc_q <= '1;
      end else if (start) begin
         // preset and first byte may come together
         if (in_byte.valid) begin
            crc_q <= crc_next('1, in_byte.data);
         end else begin
            crc_q <= '1;
         end
      end else if (in_byte.valid) begin
         crc_q <= crc_next(crc_q, in_byte.data);
      end
   end

   // fcs folded in too, so a good frame leaves the residue
   assign crc_ok = (crc_q == crc_residue);

endmodule

// ==== eth_rx/eth_rx_parser.sv ====
`timescale 1ns/100ps

module eth_rx_parser (
   input  logic                                RX_CLK,
   input  logic                                rst,
   input  eth_rx_pkg::rx_byte_t                in_byte,
   input  logic                                crc_ok,
   input  logic [eth_rx_pkg::mac_addr_w-1:0]   station_mac,
   input  logic                                frame_release,
   output logic                                crc_start,
   output eth_rx_pkg::buf_wr_t                 buf_wr,
   output logic                                frame_ready,
   output eth_rx_pkg::frame_info_t             frame_info,
   output logic                                crc_err_pulse,
   output logic                                busy_drop_pulse
);
   import eth_rx_pkg::*;

   parse_state_t          state;
   logic [buf_addr_w-1:0] cnt;
   logic [mac_addr_w-1:0] dest_q;
   logic [mac_addr_w-1:0] src_q;
   logic [len_w-1:0]      len_q;
   logic                  drop_busy;
   logic                  drop_len;
   logic [mac_addr_w-1:0] dest_next;
   logic [len_w-1:0]      len_next;
   logic                  dest_hit;

   // fields arrive msb byte first
   assign dest_next = {dest_q[mac_addr_w-data_w-1:0], in_byte.data};
   assign len_next  = {len_q[data_w-1:0], in_byte.data};
   assign dest_hit  = (dest_next == station_mac) || (dest_next == broadcast_mac);

   assign crc_start = in_byte.valid & in_byte.sof;

   // payload goes out in the same cycle it arrives
   assign buf_wr.en   = in_byte.valid && !in_byte.sof && state == ps_payload;
   assign buf_wr.addr = cnt;
   assign buf_wr.data = in_byte.data;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         state           <= ps_wait_end;
         cnt             <= '0;
         dest_q          <= '0;
         src_q           <= '0;
         len_q           <= '0;
         drop_busy       <= 1'b0;
         drop_len        <= 1'b0;
         frame_ready     <= 1'b0;
         frame_info      <= '0;
         crc_err_pulse   <= 1'b0;
         busy_drop_pulse <= 1'b0;
      end else begin
         crc_err_pulse   <= 1'b0;
         busy_drop_pulse <= 1'b0;
         if (frame_release) begin
            frame_ready <= 1'b0;
         end
         if (in_byte.valid && in_byte.sof) begin
            // buffer still held by host, drop this one
            dest_q    <= dest_next;
            cnt       <= 1;
            drop_busy <= frame_ready;
            drop_len  <= 1'b0;
            state     <= frame_ready ? ps_discard : ps_dest;
         end else if (in_byte.valid) begin
            case (state)
               ps_dest: begin
                  dest_q <= dest_next;
                  cnt    <= cnt + 1'b1;
                  if (cnt == 5) begin
                     cnt   <= '0;
                     state <= dest_hit ? ps_src : ps_discard;
                  end
               end
               ps_src: begin
                  src_q <= {src_q[mac_addr_w-data_w-1:0], in_byte.data};
                  cnt   <= cnt + 1'b1;
                  if (cnt == 5) begin
                     cnt   <= '0;
                     state <= ps_len;
                  end
               end
               ps_len: begin
                  len_q <= len_next;
                  cnt   <= cnt + 1'b1;
                  if (cnt == 1) begin
                     cnt <= '0;
                     if (len_next > max_payload) begin
                        drop_len <= 1'b1;
                        state    <= ps_discard;
                     end else if (len_next == 0) begin
                        state <= ps_fcs;
                     end else begin
                        state <= ps_payload;
                     end
                  end
               end
               ps_payload: begin
                  cnt <= cnt + 1'b1;
                  if (len_w'(cnt) + 1'b1 == len_q) begin
                     state <= ps_fcs;
                  end
               end
               default: ;
            endcase
         end
         if (in_byte.eof) begin
            state <= ps_wait_end;
            case (state)
               ps_fcs: begin
                  if (crc_ok) begin
                     frame_ready        <= 1'b1;
                     frame_info.src_mac <= src_q;
                     frame_info.length  <= len_q;
                  end else begin
                     crc_err_pulse <= 1'b1;
                  end
               end
               ps_discard: begin
                  // address miss leaves both flags low
                  busy_drop_pulse <= drop_busy;
                  crc_err_pulse   <= drop_len;
               end
               ps_wait_end: ;
               // truncated before the fcs
               default: crc_err_pulse <= 1'b1;
            endcase
         end
      end
   end

endmodule

// ==== eth_rx/mii_nibble_rx.sv ====
`timescale 1ns/100ps

module mii_nibble_rx (
   input  logic                 RX_CLK,
   input  logic                 rst,
   input  logic                 rx_dv,
   input  logic [3:0]           rx_data,
   output eth_rx_pkg::rx_byte_t rx_byte
);
   import eth_rx_pkg::*;

   rx_state_t         state;
   logic [3:0]        low_nib;
   logic              sfd_seen;
   logic              bad_pre;
   logic              first_byte;
   logic [data_w-1:0] assembled;

   // low nibble arrives first on the wire
   assign assembled = {rx_data, low_nib};

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         state      <= rx_idle;
         low_nib    <= '0;
         sfd_seen   <= 1'b0;
         bad_pre    <= 1'b0;
         first_byte <= 1'b0;
         rx_byte    <= '0;
      end else begin
         rx_byte.valid <= 1'b0;
         rx_byte.sof   <= 1'b0;
         rx_byte.eof   <= 1'b0;
         case (state)
            rx_idle: begin
               sfd_seen <= 1'b0;
               bad_pre  <= 1'b0;
               if (rx_dv) begin
                  low_nib <= rx_data;
                  state   <= rx_high_nibble;
               end
            end
            rx_low_nibble: begin
               if (rx_dv) begin
                  low_nib <= rx_data;
                  state   <= rx_high_nibble;
               end else begin
                  rx_byte.eof <= sfd_seen;
                  state       <= rx_idle;
               end
            end
            default: begin
               if (!rx_dv) begin
                  // dv dropped mid byte, the frame ends anyway
                  rx_byte.eof <= sfd_seen;
                  state       <= rx_idle;
               end else begin
                  state <= rx_low_nibble;
                  if (sfd_seen) begin
                     rx_byte.valid <= 1'b1;
                     rx_byte.sof   <= first_byte;
                     rx_byte.data  <= assembled;
                     first_byte    <= 1'b0;
                  end else if (assembled == sfd_byte && !bad_pre) begin
                     sfd_seen   <= 1'b1;
                     first_byte <= 1'b1;
                  end else if (assembled != preamble_byte) begin
                     // garbage before sfd, ignore rest of burst
                     bad_pre <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

endmodule

// ==== list.f ====
+incdir+tests
common/eth_rx_pkg.sv
eth_rx/mii_nibble_rx.sv
eth_rx/eth_crc32.sv
eth_rx/eth_rx_parser.sv
rtl/rx_frame_buffer.sv
rtl/eth_rx_regs.sv
rtl/eth_rx_top.sv
tests/eth_rx_tb.sv

// ==== rtl/eth_rx_regs.sv ====
`timescale 1ns/100ps

module eth_rx_regs (
   input  logic                                    RX_CLK,
   input  logic                                    rst,
   input  logic [eth_rx_pkg::axi_addr_w-1:0]       awaddr,
   input  logic                                    awvalid,
   output logic                                    awready,
   input  logic [eth_rx_pkg::axi_data_w-1:0]       wdata,
   input  logic [3:0]                              wstrb,
   input  logic                                    wvalid,
   output logic                                    wready,
   output logic [1:0]                              bresp,
   output logic                                    bvalid,
   input  logic                                    bready,
   input  logic [eth_rx_pkg::axi_addr_w-1:0]       araddr,
   input  logic                                    arvalid,
   output logic                                    arready,
   output logic [eth_rx_pkg::axi_data_w-1:0]       rdata,
   output logic [1:0]                              rresp,
   output logic                                    rvalid,
   input  logic                                    rready,
   input  logic                                    frame_ready,
   input  eth_rx_pkg::frame_info_t                 frame_info,
   input  logic                                    crc_err_pulse,
   input  logic                                    busy_drop_pulse,
   output logic [eth_rx_pkg::mac_addr_w-1:0]       station_mac,
   output logic                                    frame_release,
   output logic [eth_rx_pkg::buf_word_addr_w-1:0]  buf_rd_addr,
   input  logic [eth_rx_pkg::axi_data_w-1:0]       buf_rd_data
);
   import eth_rx_pkg::*;

   logic                  wr_fire;
   logic                  ar_fire;
   logic                  rd_pend;
   logic [axi_addr_w-1:0] rd_addr_q;
   logic [axi_addr_w-1:0] win_off;
   logic [axi_data_w-1:0] rdata_q;
   logic [axi_data_w-1:0] reg_mux;
   logic [15:0]           err_cnt;
   logic [15:0]           drop_cnt;

   assign wready  = awready;
   assign wr_fire = awready && awvalid && wready && wvalid;
   assign ar_fire = arready && arvalid;
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   assign frame_release = wr_fire && awaddr == reg_control && wstrb[0] && wdata[0];

   // window offset to word index
   assign win_off     = rd_addr_q - buf_window_base;
   assign buf_rd_addr = win_off[buf_word_addr_w+1:2];

   always_comb begin
      case (rd_addr_q)
         reg_status:   reg_mux = {31'b0, frame_ready};
         reg_mac_lo:   reg_mux = station_mac[31:0];
         reg_mac_hi:   reg_mux = {16'b0, station_mac[47:32]};
         reg_src_lo:   reg_mux = frame_info.src_mac[31:0];
         reg_src_hi:   reg_mux = {16'b0, frame_info.src_mac[47:32]};
         reg_length:   reg_mux = {16'b0, frame_info.length};
         reg_counters: reg_mux = {drop_cnt, err_cnt};
         default:      reg_mux = '0;
      endcase
   end

   assign rdata = (rd_addr_q >= buf_window_base) ? buf_rd_data : rdata_q;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         awready     <= 1'b0;
         bvalid      <= 1'b0;
         arready     <= 1'b0;
         rvalid      <= 1'b0;
         rd_pend     <= 1'b0;
         rd_addr_q   <= '0;
         rdata_q     <= '0;
         station_mac <= '0;
         err_cnt     <= '0;
         drop_cnt    <= '0;
      end else begin
         // write side, aw and w taken together
         awready <= awvalid && wvalid && !awready && !bvalid;
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (wr_fire && awaddr == reg_mac_lo) begin
            for (int i = 0; i < 4; i++) begin
               if (wstrb[i]) begin
                  station_mac[i*8 +: 8] <= wdata[i*8 +: 8];
               end
            end
         end
         if (wr_fire && awaddr == reg_mac_hi) begin
            for (int i = 0; i < 2; i++) begin
               if (wstrb[i]) begin
                  station_mac[32+i*8 +: 8] <= wdata[i*8 +: 8];
               end
            end
         end

         // read side, extra cycle for the buffer
         arready <= arvalid && !arready && !rd_pend && !rvalid;
         if (ar_fire) begin
            rd_addr_q <= araddr;
            rd_pend   <= 1'b1;
         end
         if (rd_pend) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b1;
            rdata_q <= reg_mux;
         end else if (rvalid && rready) begin
            rvalid <= 1'b0;
         end

         // saturating error counters
         if (crc_err_pulse && err_cnt != '1) begin
            err_cnt <= err_cnt + 1'b1;
         end
         if (busy_drop_pulse && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== rtl/eth_rx_top.sv ====
`timescale 1ns/100ps

module eth_rx_top (
   input  logic                               RX_CLK,
   input  logic                               rst,
   input  logic                               rx_dv,
   input  logic [3:0]                         rx_data,
   input  logic [eth_rx_pkg::axi_addr_w-1:0]  s_axi_awaddr,
   input  logic                               s_axi_awvalid,
   output logic                               s_axi_awready,
   input  logic [eth_rx_pkg::axi_data_w-1:0]  s_axi_wdata,
   input  logic [3:0]                         s_axi_wstrb,
   input  logic                               s_axi_wvalid,
   output logic                               s_axi_wready,
   output logic [1:0]                         s_axi_bresp,
   output logic                               s_axi_bvalid,
   input  logic                               s_axi_bready,
   input  logic [eth_rx_pkg::axi_addr_w-1:0]  s_axi_araddr,
   input  logic                               s_axi_arvalid,
   output logic                               s_axi_arready,
   output logic [eth_rx_pkg::axi_data_w-1:0]  s_axi_rdata,
   output logic [1:0]                         s_axi_rresp,
   output logic                               s_axi_rvalid,
   input  logic                               s_axi_rready
);
   import eth_rx_pkg::*;

   rx_byte_t                   rx_byte;
   logic                       crc_start;
   logic                       crc_ok;
   buf_wr_t                    buf_wr;
   logic                       frame_ready;
   frame_info_t                frame_info;
   logic                       crc_err_pulse;
   logic                       busy_drop_pulse;
   logic [mac_addr_w-1:0]      station_mac;
   logic                       frame_release;
   logic [buf_word_addr_w-1:0] buf_rd_addr;
   logic [axi_data_w-1:0]      buf_rd_data;

   mii_nibble_rx u_nibble_rx (
      .RX_CLK  (RX_CLK),
      .rst     (rst),
      .rx_dv   (rx_dv),
      .rx_data (rx_data),
      .rx_byte (rx_byte)
   );

   eth_crc32 u_crc (
      .RX_CLK  (RX_CLK),
      .rst     (rst),
      .start   (crc_start),
      .in_byte (rx_byte),
      .crc_ok  (crc_ok)
   );

   eth_rx_parser u_parser (
      .RX_CLK          (RX_CLK),
      .rst             (rst),
      .in_byte         (rx_byte),
      .crc_ok          (crc_ok),
      .station_mac     (station_mac),
      .frame_release   (frame_release),
      .crc_start       (crc_start),
      .buf_wr          (buf_wr),
      .frame_ready     (frame_ready),
      .frame_info      (frame_info),
      .crc_err_pulse   (crc_err_pulse),
      .busy_drop_pulse (busy_drop_pulse)
   );

   rx_frame_buffer u_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (buf_wr),
      .rd_addr (buf_rd_addr),
      .rd_data (buf_rd_data)
   );

   eth_rx_regs u_regs (
      .RX_CLK          (RX_CLK),
      .rst             (rst),
      .awaddr          (s_axi_awaddr),
      .awvalid         (s_axi_awvalid),
      .awready         (s_axi_awready),
      .wdata           (s_axi_wdata),
      .wstrb           (s_axi_wstrb),
      .wvalid          (s_axi_wvalid),
      .wready          (s_axi_wready),
      .bresp           (s_axi_bresp),
      .bvalid          (s_axi_bvalid),
      .bready          (s_axi_bready),
      .araddr          (s_axi_araddr),
      .arvalid         (s_axi_arvalid),
      .arready         (s_axi_arready),
      .rdata           (s_axi_rdata),
      .rresp           (s_axi_rresp),
      .rvalid          (s_axi_rvalid),
      .rready          (s_axi_rready),
      .frame_ready     (frame_ready),
      .frame_info      (frame_info),
      .crc_err_pulse   (crc_err_pulse),
      .busy_drop_pulse (busy_drop_pulse),
      .station_mac     (station_mac),
      .frame_release   (frame_release),
      .buf_rd_addr     (buf_rd_addr),
      .buf_rd_data     (buf_rd_data)
   );

endmodule

// ==== rtl/rx_frame_buffer.sv ====
`timescale 1ns/100ps

module rx_frame_buffer (
   input  logic                                     RX_CLK,
   input  eth_rx_pkg::buf_wr_t                      wr,
   input  logic [eth_rx_pkg::buf_word_addr_w-1:0]   rd_addr,
   output logic [eth_rx_pkg::axi_data_w-1:0]        rd_data
);
   import eth_rx_pkg::*;

   logic [axi_data_w-1:0] mem [0:(1 << buf_word_addr_w)-1];

   always_ff @(posedge RX_CLK) begin
      // byte lane from the low address bits
      if (wr.en) begin
         mem[wr.addr[buf_addr_w-1:2]][wr.addr[1:0]*data_w +: data_w] <= wr.data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module eth_rx_tb -o eth_rx_sim

sim_status=0
./obj_dir/eth_rx_sim > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "simulation failed"
   exit 1
fi
if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
echo "simulation passed"

// ==== tests/eth_rx_tb_frames.svh ====
// columns are dest mac, src mac, payload length, payload seed,
// corrupt fcs, release the held frame first, expected outcome
`ifndef eth_rx_tb_frames_svh
`define eth_rx_tb_frames_svh

localparam logic [1:0] out_accept    = 2'd0;
localparam logic [1:0] out_filter    = 2'd1;
localparam logic [1:0] out_crc_error = 2'd2;
localparam logic [1:0] out_busy      = 2'd3;

localparam logic [47:0] station_addr = 48'h02_1B_44_9C_70_E5;
localparam logic [47:0] other_addr   = 48'h02_1B_44_9C_70_E4;
localparam logic [47:0] bcast_addr   = 48'hFFFF_FFFF_FFFF;
localparam int          n_frames     = 9;

typedef struct packed {
   logic [47:0] dest;
   logic [47:0] src;
   int          len;
   int          pay_seed;
   logic        corrupt_fcs;
   logic        release_before;
   logic [1:0]  outcome;
} frame_entry_t;

frame_entry_t frame_table [0:n_frames-1];

function automatic void load_frame_table();
   frame_table[0] = '{station_addr, 48'h02_A0_00_00_00_01, 46, 1, 1'b0, 1'b0, out_accept};
   frame_table[1] = '{bcast_addr, 48'h02_A0_00_00_00_02, 61, 2, 1'b0, 1'b1, out_accept};
   // differs from the station only in the last byte
   frame_table[2] = '{other_addr, 48'h02_A0_00_00_00_03, 50, 3, 1'b0, 1'b1, out_filter};
   frame_table[3] = '{station_addr, 48'h02_A0_00_00_00_04, 40, 4, 1'b1, 1'b0, out_crc_error};
   frame_table[4] = '{station_addr, 48'h02_A0_00_00_00_05, 1501, 5, 1'b0, 1'b0, out_crc_error};
   frame_table[5] = '{station_addr, 48'h02_A0_00_00_00_06, 1500, 6, 1'b0, 1'b0, out_accept};
   frame_table[6] = '{station_addr, 48'h02_A0_00_00_00_07, 77, 7, 1'b0, 1'b0, out_busy};
   frame_table[7] = '{bcast_addr, 48'h02_A0_00_00_00_08, 1, 8, 1'b0, 1'b0, out_busy};
   frame_table[8] = '{station_addr, 48'h02_A0_00_00_00_09, 9, 9, 1'b0, 1'b1, out_accept};
endfunction

`endif

// ==== tests/eth_rx_tb.sv ====
`timescale 1ns/100ps

module eth_rx_tb;
   import eth_rx_pkg::*;

   `include "eth_rx_tb_frames.svh"

   localparam int rand_seed    = 91408;
   localparam int frame_margin = 2500;
   localparam int setup_cycles = 500;
   localparam int poll_tries   = 50;

   logic        RX_CLK;
   logic        rst;
   logic        rx_dv;
   logic [3:0]  rx_data;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   integer      seed;
   logic [7:0]  frame_q [$];
   logic [7:0]  pay [0:1599];
   logic [7:0]  held_pay [0:1599];
   logic [47:0] held_src;
   int          held_len;
   logic        held;
   logic [15:0] err_exp;
   logic [15:0] drop_exp;
   logic [31:0] rd_val;

   eth_rx_top i_dut (
      .RX_CLK        (RX_CLK),
      .rst           (rst),
      .rx_dv         (rx_dv),
      .rx_data       (rx_data),
      .s_axi_awaddr  (awaddr),
      .s_axi_awvalid (awvalid),
      .s_axi_awready (awready),
      .s_axi_wdata   (wdata),
      .s_axi_wstrb   (wstrb),
      .s_axi_wvalid  (wvalid),
      .s_axi_wready  (wready),
      .s_axi_bresp   (bresp),
      .s_axi_bvalid  (bvalid),
      .s_axi_bready  (bready),
      .s_axi_araddr  (araddr),
      .s_axi_arvalid (arvalid),
      .s_axi_arready (arready),
      .s_axi_rdata   (rdata),
      .s_axi_rresp   (rresp),
      .s_axi_rvalid  (rvalid),
      .s_axi_rready  (rready)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
      if (got !== exp_val) begin
         abort_run($sformatf("ERR at %0t: %s got %08h expected %08h",
                             $time, name, got, exp_val));
      end
   endtask

   // reflected crc-32, byte folded in before the shifts
   function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
      logic [31:0] r;
      r = c ^ {24'h0, b};
      repeat (8) begin
         r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
      end
      return r;
   endfunction

   // drive on the rising edge, sample on the falling edge
   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
      logic aw_done;
      logic w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge RX_CLK);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= 4'hF;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      // address and data channels may complete in different cycles
      while (!(aw_done && w_done)) begin
         @(negedge RX_CLK);
         if (awready) begin
            aw_done = 1'b1;
         end
         if (wready) begin
            w_done = 1'b1;
         end
         @(posedge RX_CLK);
         if (aw_done) begin
            awvalid <= 1'b0;
         end
         if (w_done) begin
            wvalid <= 1'b0;
         end
      end
      @(negedge RX_CLK);
      while (!bvalid) @(negedge RX_CLK);
      check_value("bresp", {30'b0, bresp}, 32'h0);
      @(posedge RX_CLK);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge RX_CLK);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      @(negedge RX_CLK);
      while (!arready) @(negedge RX_CLK);
      @(posedge RX_CLK);
      arvalid <= 1'b0;
      @(negedge RX_CLK);
      while (!rvalid) @(negedge RX_CLK);
      data = rdata;
      check_value("rresp", {30'b0, rresp}, 32'h0);
      @(posedge RX_CLK);
      rready <= 1'b0;
   endtask

   task automatic poll_reg(input logic [11:0] addr, input logic [31:0] exp_val,
                           input string what);
      logic [31:0] v;
      int          tries;
      tries = 0;
      v = ~exp_val;
      while (v !== exp_val && tries < poll_tries) begin
         axi_read(addr, v);
         tries++;
      end
      if (v !== exp_val) begin
         abort_run($sformatf("%s never showed up in register %03h", what, addr));
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(posedge RX_CLK);
      rx_dv   <= 1'b1;
      rx_data <= b[3:0];
      @(posedge RX_CLK);
      rx_data <= b[7:4];
   endtask

   task automatic build_frame(input frame_entry_t f);
      logic [31:0] crc;
      logic [31:0] rnd;
      frame_q.delete();
      for (int i = 5; i >= 0; i--) begin
         frame_q.push_back(f.dest[i*8 +: 8]);
      end
      for (int i = 5; i >= 0; i--) begin
         frame_q.push_back(f.src[i*8 +: 8]);
      end
      frame_q.push_back(f.len[15:8]);
      frame_q.push_back(f.len[7:0]);
      seed = rand_seed + f.pay_seed;
      for (int i = 0; i < f.len; i++) begin
         rnd = $random(seed);
         pay[i] = rnd[7:0];
         frame_q.push_back(rnd[7:0]);
      end
      crc = 32'hFFFF_FFFF;
      foreach (frame_q[i]) begin
         crc = crc_step(crc, frame_q[i]);
      end
      crc = ~crc;
      if (f.corrupt_fcs) begin
         crc[8] = ~crc[8];
      end
      // fcs goes out least significant byte first
      for (int i = 0; i < 4; i++) begin
         frame_q.push_back(crc[i*8 +: 8]);
      end
   endtask

   task automatic send_frame();
      repeat (7) send_byte(preamble_byte);
      send_byte(sfd_byte);
      foreach (frame_q[i]) begin
         send_byte(frame_q[i]);
      end
      @(posedge RX_CLK);
      rx_dv   <= 1'b0;
      rx_data <= 4'h0;
      // interframe gap
      repeat (12) @(posedge RX_CLK);
   endtask

   task automatic check_held();
      logic [31:0] v;
      logic [31:0] exp_w;
      logic [31:0] mask;
      axi_read(reg_src_lo, v);
      check_value("src_lo", v, held_src[31:0]);
      axi_read(reg_src_hi, v);
      check_value("src_hi", v, {16'h0, held_src[47:32]});
      axi_read(reg_length, v);
      check_value("length", v, {16'h0, held_len[15:0]});
      for (int w = 0; w < (held_len + 3) / 4; w++) begin
         exp_w = '0;
         mask  = '0;
         // lanes past the payload end hold stale data
         for (int b = 0; b < 4; b++) begin
            if (w * 4 + b < held_len) begin
               exp_w[b*8 +: 8] = held_pay[w*4+b];
               mask[b*8 +: 8]  = 8'hFF;
            end
         end
         axi_read(buf_window_base + 12'(w * 4), v);
         check_value($sformatf("buf_word[%0d]", w), v & mask, exp_w);
      end
   endtask

   task automatic release_frame();
      logic [31:0] v;
      axi_write(reg_control, 32'h1);
      axi_read(reg_status, v);
      check_value("status after release", v, 32'h0);
      held = 1'b0;
   endtask

   task automatic run_frame(input int idx);
      frame_entry_t f;
      logic [31:0]  v;
      f = frame_table[idx];
      if (f.release_before && held) begin
         release_frame();
      end
      build_frame(f);
      send_frame();
      case (f.outcome)
         out_accept: begin
            poll_reg(reg_status, 32'h1, "frame ready");
            held     = 1'b1;
            held_src = f.src;
            held_len = f.len;
            held_pay = pay;
            check_held();
            axi_read(reg_counters, v);
            check_value("counters", v, {drop_exp, err_exp});
         end
         out_filter: begin
            repeat (8) begin
               axi_read(reg_counters, v);
               check_value("counters", v, {drop_exp, err_exp});
            end
            axi_read(reg_status, v);
            check_value("status", v, {31'b0, held});
         end
         out_crc_error: begin
            err_exp = err_exp + 16'd1;
            poll_reg(reg_counters, {drop_exp, err_exp}, "error count");
            axi_read(reg_status, v);
            check_value("status", v, {31'b0, held});
         end
         default: begin
            drop_exp = drop_exp + 16'd1;
            poll_reg(reg_counters, {drop_exp, err_exp}, "busy drop count");
            axi_read(reg_status, v);
            check_value("status", v, 32'h1);
            check_held();
         end
      endcase
   endtask

   initial begin
      int cycles;
      @(posedge RX_CLK);
      cycles = setup_cycles;
      for (int i = 0; i < n_frames; i++) begin
         cycles += (frame_table[i].len + 26) * 2 + frame_margin;
      end
      repeat (cycles) @(posedge RX_CLK);
      abort_run("timeout, the test did not finish within the cycle budget");
   end

   initial begin
      load_frame_table();
      seed     = rand_seed;
      rst      = 1'b1;
      rx_dv    = 1'b0;
      rx_data  = 4'h0;
      awaddr   = '0;
      awvalid  = 1'b0;
      wdata    = '0;
      wstrb    = '0;
      wvalid   = 1'b0;
      bready   = 1'b0;
      araddr   = '0;
      arvalid  = 1'b0;
      rready   = 1'b0;
      held     = 1'b0;
      held_len = 0;
      held_src = '0;
      err_exp  = '0;
      drop_exp = '0;
      repeat (2) @(posedge RX_CLK);
      rst <= 1'b0;

      axi_read(reg_status, rd_val);
      check_value("status", rd_val, 32'h0);
      axi_read(reg_counters, rd_val);
      check_value("counters", rd_val, 32'h0);
      axi_read(reg_mac_lo, rd_val);
      check_value("mac_lo", rd_val, 32'h0);
      axi_read(reg_mac_hi, rd_val);
      check_value("mac_hi", rd_val, 32'h0);

      axi_write(reg_mac_lo, station_addr[31:0]);
      axi_write(reg_mac_hi, {16'h0, station_addr[47:32]});
      axi_read(reg_mac_lo, rd_val);
      check_value("mac_lo", rd_val, station_addr[31:0]);
      axi_read(reg_mac_hi, rd_val);
      check_value("mac_hi", rd_val, {16'h0, station_addr[47:32]});

      for (int i = 0; i < n_frames; i++) begin
         run_frame(i);
      end
      if (held) begin
         release_frame();
      end
      axi_read(reg_counters, rd_val);
      check_value("counters", rd_val, {drop_exp, err_exp});

      $display("*** PASSED ***");
      $finish;
   end

endmodule
